// File: hw/roce_proto_pkg.sv
package roce_proto_pkg;

  // RDMA WRITE opcodes for the reliable connected transport
  typedef enum logic [7:0] {
    WRITE_FIRST  = 8'h06,
    WRITE_MIDDLE = 8'h07,
    WRITE_LAST   = 8'h08,
    WRITE_ONLY   = 8'h0A
  } opcode_e;

  // base transport header, only the fields this path fills in
  typedef struct packed {
    opcode_e     opcode;
    logic [15:0] p_key;
    logic [23:0] psn;
    logic [23:0] dest_qp;
    logic        ack_req;
  } bth_t;

  // RDMA extended transport header
  typedef struct packed {
    logic [63:0] v_addr;
    logic [31:0] r_key;
    logic [31:0] length;
  } reth_t;

  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dest_ip;
    logic [15:0] src_port;
    logic [15:0] dest_port;
    logic [15:0] udp_length;
  } ip_udp_t;

  // header sizes in bytes, sized for the UDP length sum
  localparam logic [15:0] BTH_BYTES     = 16'd12;
  localparam logic [15:0] RETH_BYTES    = 16'd16;
  localparam logic [15:0] UDP_HDR_BYTES = 16'd8;

  localparam logic [15:0] ROCE_UDP_PORT = 16'h12B7;
  localparam logic [15:0] LOC_UDP_PORT  = 16'h2123;
  localparam logic [31:0] LOC_IP_ADDR   = {8'd11, 8'd1, 8'd212, 8'd10};
  localparam logic [15:0] DEFAULT_P_KEY = 16'hFFFF;

  // pmtu setting in bytes, up to 8191
  localparam int PMTU_W = 13;

endpackage

// File: hw/tx_path_pkg.sv
package tx_path_pkg;
  import roce_proto_pkg::*;

  localparam int DATA_W     = 64;
  localparam int KEEP_W     = DATA_W / 8;
  localparam int BEAT_BYTES = DATA_W / 8;

  typedef struct packed {
    logic [31:0] length;
    logic [23:0] rem_qpn;
    logic [23:0] start_psn;
    logic [31:0] r_key;
    logic [31:0] rem_ip;
    logic [47:0] rem_addr;
  } dma_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic              user;
  } beat_t;

  // one per packet, from the segmenter to the header stage
  typedef struct packed {
    opcode_e     opcode;
    logic [23:0] psn;
    logic [15:0] pay_bytes;
    logic [31:0] dma_len;
    logic [23:0] rem_qpn;
    logic [31:0] r_key;
    logic [31:0] rem_ip;
    logic [47:0] rem_addr;
  } seg_desc_t;

endpackage

// File: hw/roce_segmenter.sv
`timescale 1ns/1ps

module roce_segmenter
  import roce_proto_pkg::*;
  import tx_path_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  dma_req_t          req,
  input  logic              req_valid,
  output logic              req_ready,

  input  beat_t             s_beat,
  input  logic              s_valid,
  output logic              s_ready,

  input  logic [PMTU_W-1:0] pmtu,
  input  logic              hdr_busy,
  input  logic              ready_early,

  output seg_desc_t         desc,
  output logic              desc_strobe,
  output beat_t             beat,
  output logic              beat_valid
);

  logic              active;
  logic              first_pkt;
  dma_req_t          req_q;
  logic [31:0]       remaining;
  logic [PMTU_W-1:0] pkt_left;
  logic [23:0]       psn;
  logic              out_ready_q;

  logic              req_take;
  logic              beat_take;
  logic              pkt_start;
  logic              fits;
  logic [PMTU_W-1:0] pay_bytes;
  logic [PMTU_W-1:0] cur_left;
  opcode_e           opcode;

  // nothing left of the current packet means the next beat opens a new one
  assign pkt_start = (pkt_left == '0);

  // the rest of the transfer fits into one packet
  assign fits      = (remaining <= 32'(pmtu));
  assign pay_bytes = fits ? remaining[PMTU_W-1:0] : pmtu;
  assign cur_left  = pkt_start ? pay_bytes : pkt_left;

  always_comb begin
    if (first_pkt) begin
      opcode = fits ? WRITE_ONLY : WRITE_FIRST;
    end else begin
      opcode = fits ? WRITE_LAST : WRITE_MIDDLE;
    end
  end

  assign req_ready = !active;
  assign req_take  = req_valid && req_ready;

  // out_ready_q is ready_early one cycle late, so a beat is only offered
  // when the skid buffer has room for it even if m_ready drops.
  // a packet's first beat also waits for the previous headers to leave
  assign s_ready   = active && out_ready_q && (!pkt_start || !hdr_busy);
  assign beat_take = s_valid && s_ready;

  assign desc_strobe = beat_take && pkt_start;

  always_comb begin
    desc.opcode    = opcode;
    desc.psn       = psn;
    desc.pay_bytes = 16'(pay_bytes);
    desc.dma_len   = req_q.length;
    desc.rem_qpn   = req_q.rem_qpn;
    desc.r_key     = req_q.r_key;
    desc.rem_ip    = req_q.rem_ip;
    desc.rem_addr  = req_q.rem_addr;
  end

  // input tlast is replaced by the packet boundary
  always_comb begin
    beat      = s_beat;
    beat.last = (cur_left == PMTU_W'(BEAT_BYTES));
  end

  assign beat_valid = beat_take;

  always_ff @(posedge clk) begin
    if (rst) begin
      active      <= 1'b0;
      first_pkt   <= 1'b0;
      pkt_left    <= '0;
      out_ready_q <= 1'b0;
    end else begin
      out_ready_q <= ready_early;
      if (req_take) begin
        active    <= 1'b1;
        first_pkt <= 1'b1;
        pkt_left  <= '0;
      end else if (beat_take) begin
        first_pkt <= 1'b0;
        pkt_left  <= cur_left - PMTU_W'(BEAT_BYTES);
        // final beat of the transfer
        if (remaining == 32'(BEAT_BYTES)) begin
          active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      req_q     <= req;
      remaining <= req.length;
      psn       <= req.start_psn;
    end else if (beat_take) begin
      remaining <= remaining - 32'(BEAT_BYTES);
      // one psn per packet, wraps at 2^24
      if (pkt_start) begin
        psn <= psn + 24'd1;
      end
    end
  end

endmodule

// File: hw/roce_header_gen.sv
`timescale 1ns/1ps

module roce_header_gen
  import roce_proto_pkg::*;
  import tx_path_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  seg_desc_t desc,
  input  logic      desc_strobe,
  output logic      hdr_busy,

  output bth_t      bth,
  output logic      bth_valid,
  input  logic      bth_ready,

  output reth_t     reth,
  output logic      reth_valid,
  input  logic      reth_ready,

  output ip_udp_t   ip_udp
);

  logic        has_reth;
  logic [15:0] udp_len;

  // only the packet that opens a transfer carries the RETH
  assign has_reth = (desc.opcode == WRITE_FIRST) || (desc.opcode == WRITE_ONLY);

  always_comb begin
    udp_len = desc.pay_bytes + BTH_BYTES + UDP_HDR_BYTES;
    if (has_reth) begin
      udp_len = udp_len + RETH_BYTES;
    end
  end

  assign hdr_busy = bth_valid || reth_valid;

  // header fields load on the strobe and hold until the next packet
  always_ff @(posedge clk) begin
    if (desc_strobe) begin
      bth.opcode  <= desc.opcode;
      bth.p_key   <= DEFAULT_P_KEY;
      bth.psn     <= desc.psn;
      bth.dest_qp <= desc.rem_qpn;
      bth.ack_req <= 1'b0;

      ip_udp.src_ip     <= LOC_IP_ADDR;
      ip_udp.dest_ip    <= desc.rem_ip;
      ip_udp.src_port   <= LOC_UDP_PORT;
      ip_udp.dest_port  <= ROCE_UDP_PORT;
      ip_udp.udp_length <= udp_len;

      if (has_reth) begin
        reth.v_addr <= 64'(desc.rem_addr);
        reth.r_key  <= desc.r_key;
        reth.length <= desc.dma_len;
      end
    end
  end

  // the strobe never comes while a header is pending, since the
  // segmenter holds a packet's first beat on hdr_busy
  always_ff @(posedge clk) begin
    if (rst) begin
      bth_valid  <= 1'b0;
      reth_valid <= 1'b0;
    end else begin
      if (desc_strobe) begin
        bth_valid <= 1'b1;
      end else if (bth_ready) begin
        bth_valid <= 1'b0;
      end

      if (desc_strobe) begin
        reth_valid <= has_reth;
      end else if (reth_ready) begin
        reth_valid <= 1'b0;
      end
    end
  end

endmodule

// File: hw/payload_skid_buffer.sv
`timescale 1ns/1ps

module payload_skid_buffer
  import tx_path_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  beat_t beat,
  input  logic  beat_valid,
  output logic  ready_early,

  output beat_t m_beat,
  output logic  m_valid,
  input  logic  m_ready
);

  beat_t tmp_beat;
  logic  tmp_valid;
  logic  m_valid_next;
  logic  tmp_valid_next;
  logic  out_load_in;
  logic  out_load_tmp;
  logic  tmp_load_in;

  // room next cycle if the output drains now or nothing is held
  assign ready_early = m_ready || (!m_valid && !tmp_valid);

  always_comb begin
    m_valid_next   = m_valid;
    tmp_valid_next = tmp_valid;
    out_load_in    = 1'b0;
    out_load_tmp   = 1'b0;
    tmp_load_in    = 1'b0;

    if (beat_valid) begin
      if (m_ready || !m_valid) begin
        // output free, beat goes straight through
        m_valid_next = 1'b1;
        out_load_in  = 1'b1;
      end else begin
        // output stalled, park the beat
        tmp_valid_next = 1'b1;
        tmp_load_in    = 1'b1;
      end
    end else if (m_ready) begin
      m_valid_next   = tmp_valid;
      tmp_valid_next = 1'b0;
      out_load_tmp   = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid   <= 1'b0;
      tmp_valid <= 1'b0;
    end else begin
      m_valid   <= m_valid_next;
      tmp_valid <= tmp_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load_in) begin
      m_beat <= beat;
    end else if (out_load_tmp) begin
      m_beat <= tmp_beat;
    end

    if (tmp_load_in) begin
      tmp_beat <= beat;
    end
  end

endmodule

// File: hw/roce_tx_top.sv
`timescale 1ns/1ps

module roce_tx_top
  import roce_proto_pkg::*;
  import tx_path_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  dma_req_t          req,
  input  logic              req_valid,
  output logic              req_ready,

  input  beat_t             s_beat,
  input  logic              s_valid,
  output logic              s_ready,

  input  logic [PMTU_W-1:0] pmtu,

  output bth_t              bth,
  output logic              bth_valid,
  input  logic              bth_ready,
  output reth_t             reth,
  output logic              reth_valid,
  input  logic              reth_ready,
  output ip_udp_t           ip_udp,

  output beat_t             m_beat,
  output logic              m_valid,
  input  logic              m_ready
);

  seg_desc_t desc;
  logic      desc_strobe;
  logic      hdr_busy;
  beat_t     beat;
  logic      beat_valid;
  logic      ready_early;

  roce_segmenter i_roce_segmenter (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .s_beat      (s_beat),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .pmtu        (pmtu),
    .hdr_busy    (hdr_busy),
    .ready_early (ready_early),
    .desc        (desc),
    .desc_strobe (desc_strobe),
    .beat        (beat),
    .beat_valid  (beat_valid)
  );

  roce_header_gen i_roce_header_gen (
    .clk         (clk),
    .rst         (rst),
    .desc        (desc),
    .desc_strobe (desc_strobe),
    .hdr_busy    (hdr_busy),
    .bth         (bth),
    .bth_valid   (bth_valid),
    .bth_ready   (bth_ready),
    .reth        (reth),
    .reth_valid  (reth_valid),
    .reth_ready  (reth_ready),
    .ip_udp      (ip_udp)
  );

  payload_skid_buffer i_payload_skid_buffer (
    .clk         (clk),
    .rst         (rst),
    .beat        (beat),
    .beat_valid  (beat_valid),
    .ready_early (ready_early),
    .m_beat      (m_beat),
    .m_valid     (m_valid),
    .m_ready     (m_ready)
  );

endmodule

// File: tests/roce_tx_properties.sv
`timescale 1ns/1ps

module roce_tx_properties
  import roce_proto_pkg::*;
  import tx_path_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    req_ready,
  input bth_t    bth,
  input logic    bth_valid,
  input logic    bth_ready,
  input reth_t   reth,
  input logic    reth_valid,
  input logic    reth_ready,
  input ip_udp_t ip_udp,
  input beat_t   m_beat,
  input logic    m_valid,
  input logic    m_ready
);

  // idle outputs in the cycle after reset
  assert property (@(posedge clk) rst |=> !bth_valid && !reth_valid && !m_valid && req_ready)
    else $error("outputs not idle after reset");

  // a header waiting for its ready holds its fields
  assert property (@(posedge clk) disable iff (rst)
    bth_valid && !bth_ready |=> bth_valid && $stable(bth) && $stable(ip_udp))
    else $error("BTH or IP/UDP fields changed while waiting for bth_ready");

  assert property (@(posedge clk) disable iff (rst)
    reth_valid && !reth_ready |=> reth_valid && $stable(reth))
    else $error("RETH changed while waiting for reth_ready");

  // RETH only goes with the packet that opens a transfer
  assert property (@(posedge clk) disable iff (rst)
    reth_valid |-> bth.opcode inside {WRITE_FIRST, WRITE_ONLY})
    else $error("RETH valid with a MIDDLE or LAST opcode");

  assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("payload beat changed while waiting for m_ready");

endmodule

bind roce_tx_top roce_tx_properties i_roce_tx_properties (
  .clk        (clk),
  .rst        (rst),
  .req_ready  (req_ready),
  .bth        (bth),
  .bth_valid  (bth_valid),
  .bth_ready  (bth_ready),
  .reth       (reth),
  .reth_valid (reth_valid),
  .reth_ready (reth_ready),
  .ip_udp     (ip_udp),
  .m_beat     (m_beat),
  .m_valid    (m_valid),
  .m_ready    (m_ready)
);

// File: tests/roce_tx_tb.sv
`timescale 1ns/1ps

module roce_tx_tb
  import roce_proto_pkg::*;
  import tx_path_pkg::*;
();

  localparam int TIMEOUT  = 2000;
  localparam int N_RANDOM = 30;

  logic              clk;
  logic              rst;
  dma_req_t          req;
  logic              req_valid;
  logic              req_ready;
  beat_t             s_beat;
  logic              s_valid;
  logic              s_ready;
  logic [PMTU_W-1:0] pmtu;
  bth_t              bth;
  logic              bth_valid;
  logic              bth_ready;
  reth_t             reth;
  logic              reth_valid;
  logic              reth_ready;
  ip_udp_t           ip_udp;
  beat_t             m_beat;
  logic              m_valid;
  logic              m_ready;

  logic [15:0] lfsr = 16'd26;

  // reference model filled as each transfer is built
  bth_t    exp_bth[$];
  ip_udp_t exp_ip[$];
  reth_t   exp_reth[$];
  beat_t   exp_beats[$];
  beat_t   in_beats[$];

  roce_tx_top i_roce_tx_top (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
  endtask

  task automatic advance_cycle(inout int cyc, input string what);
    @(posedge clk);
    cyc++;
    if (cyc > TIMEOUT) begin
      abort_run($sformatf("timed out after %0d cycles waiting for %s", TIMEOUT, what));
    end
  endtask

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
  endfunction

  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic build_expected(input logic [PMTU_W-1:0] p, input dma_req_t r);
    int      n_pkt;
    int      pay;
    logic    has_reth;
    bth_t    b;
    ip_udp_t u;
    beat_t   t;
    n_pkt = (int'(r.length) + int'(p) - 1) / int'(p);
    for (int k = 0; k < n_pkt; k++) begin
      pay      = (k == n_pkt - 1) ? int'(r.length) - k * int'(p) : int'(p);
      has_reth = (k == 0);
      b.opcode = opcode_e'((n_pkt == 1) ? WRITE_ONLY : (k == 0) ? WRITE_FIRST :
                           (k == n_pkt - 1) ? WRITE_LAST : WRITE_MIDDLE);
      b.p_key   = 16'hFFFF;
      b.psn     = r.start_psn + 24'(k);
      b.dest_qp = r.rem_qpn;
      b.ack_req = 1'b0;
      u.src_ip     = {8'd11, 8'd1, 8'd212, 8'd10};
      u.dest_ip    = r.rem_ip;
      u.src_port   = 16'h2123;
      u.dest_port  = 16'h12B7;
      u.udp_length = 16'(pay + 20 + (has_reth ? 16 : 0));
      exp_bth.push_back(b);
      exp_ip.push_back(u);
      if (has_reth) begin
        exp_reth.push_back(reth_t'{v_addr: 64'(r.rem_addr), r_key: r.r_key,
                                   length: r.length});
      end
    end
    for (int i = 0; i < int'(r.length) / 8; i++) begin
      t.data = draw_bits(64);
      t.keep = 8'hFF;
      t.user = 1'(draw_bits(1));
      t.last = 1'(draw_bits(1));
      in_beats.push_back(t);
      // framing follows the length and ignores input last
      t.last = (((i + 1) * 8) % int'(p) == 0) || ((i + 1) * 8 == int'(r.length));
      exp_beats.push_back(t);
    end
  endtask

  task automatic send_transfer(input logic [PMTU_W-1:0] p, input logic [31:0] len,
                               input logic [23:0] psn0);
    dma_req_t r;
    int       cyc;
    // request fields are drawn on the rising edge and ready gaps on the falling one
    @(posedge clk);
    r.length    = len;
    r.start_psn = psn0;
    r.rem_qpn   = 24'(draw_bits(24));
    r.r_key     = 32'(draw_bits(32));
    r.rem_ip    = 32'(draw_bits(32));
    r.rem_addr  = 48'(draw_bits(48));
    build_expected(p, r);
    @(negedge clk);
    pmtu      = p;
    req       = r;
    req_valid = 1'b1;
    cyc = 0;
    do begin
      advance_cycle(cyc, "request handshake");
    end while (!req_ready);
    @(negedge clk);
    req_valid = 1'b0;
    while (in_beats.size() != 0) begin
      s_valid = 1'b1;
      s_beat  = in_beats.pop_front();
      cyc = 0;
      do begin
        advance_cycle(cyc, "payload beat acceptance");
      end while (!s_ready);
      @(negedge clk);
    end
    s_valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    m_ready    = 1'b0;
    bth_ready  = 1'b0;
    reth_ready = 1'b0;
    forever begin
      @(negedge clk);
      // output ready about three cycles in four
      m_ready    = (draw_bits(2) != 64'd0);
      bth_ready  = 1'(draw_bits(1));
      reth_ready = 1'(draw_bits(1));
    end
  end

  always @(posedge clk) begin
    if (!rst && bth_valid && bth_ready) begin
      assert (exp_bth.size() != 0) else abort_run("BTH handshake with no packet outstanding");
      assert (bth === exp_bth[0])
        else report_mismatch($sformatf("BTH %h, expected %h", bth, exp_bth[0]));
      assert (ip_udp === exp_ip[0])
        else report_mismatch($sformatf("IP/UDP %h, expected %h", ip_udp, exp_ip[0]));
      exp_bth.delete(0);
      exp_ip.delete(0);
    end
    if (!rst && reth_valid && reth_ready) begin
      assert (exp_reth.size() != 0) else abort_run("RETH handshake on a packet without RETH");
      assert (bth.opcode inside {WRITE_FIRST, WRITE_ONLY})
        else report_mismatch($sformatf("RETH sent with opcode %h", bth.opcode));
      assert (reth === exp_reth[0])
        else report_mismatch($sformatf("RETH %h, expected %h", reth, exp_reth[0]));
      exp_reth.delete(0);
    end
    if (!rst && m_valid && m_ready) begin
      assert (exp_beats.size() != 0) else abort_run("output beat with no input beat outstanding");
      assert (m_beat === exp_beats[0])
        else report_mismatch($sformatf("beat %h, expected %h", m_beat, exp_beats[0]));
      exp_beats.delete(0);
    end
  end

  initial begin
    int                cyc;
    logic [PMTU_W-1:0] p;
    logic [31:0]       len;
    logic [23:0]       psn0;
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    s_beat    = '0;
    s_valid   = 1'b0;
    pmtu      = PMTU_W'(64);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!bth_valid && !reth_valid && !m_valid && req_ready)
      else report_mismatch("outputs not idle after reset");

    // single packets below and at pmtu, then a multi-packet transfer across the psn wrap
    send_transfer(PMTU_W'(64), 32'd48, 24'h000100);
    send_transfer(PMTU_W'(64), 32'd64, 24'h000200);
    send_transfer(PMTU_W'(32), 32'd136, 24'hFFFFFE);
    for (int t = 0; t < N_RANDOM; t++) begin
      @(posedge clk);
      p    = PMTU_W'(8 * (1 + draw_bits(5)));
      len  = 32'(8 * (1 + draw_bits(6)));
      psn0 = 24'(draw_bits(24));
      send_transfer(p, len, psn0);
    end

    cyc = 0;
    while (exp_beats.size() != 0 || exp_bth.size() != 0 || exp_reth.size() != 0) begin
      @(negedge clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        abort_run("timed out waiting for the remaining headers and beats to leave");
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: roce_tx.f
hw/roce_proto_pkg.sv
hw/tx_path_pkg.sv
hw/roce_segmenter.sv
hw/roce_header_gen.sv
hw/payload_skid_buffer.sv
hw/roce_tx_top.sv
tests/roce_tx_properties.sv
tests/roce_tx_tb.sv

// File: Makefile
TOP := roce_tx_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): roce_tx.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --timing --assert -f roce_tx.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	verilator --lint-only --timing --assert -f roce_tx.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
